//--- vlog.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_stage_if.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_memory.sv
logic/rv_writeback.sv
logic/rv_core.sv
test/rv_core_tb.sv

//--- test/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

  localparam int ROM_WORDS = 64;
  localparam int RAM_WORDS = 256;
  localparam int MAX_ROWS  = 64;

  // Operand values used by the main program
  localparam logic [31:0] BASE   = 32'h0000_0100;
  localparam logic [31:0] V1     = 32'h1234_5000;
  localparam logic [31:0] V2     = 32'h0000_06a5;
  localparam logic [31:0] V3     = 32'hffff_fff0;
  // Dependent chain results
  localparam logic [31:0] V11    = V1 + 32'h123;
  localparam logic [31:0] V12    = V11 + V2;
  localparam logic [31:0] V13    = V12 - V11;
  localparam logic [31:0] V14    = V13 ^ V12;
  // Address of the JAL row
  localparam logic [31:0] JAL_PC = 32'd136;

  logic        clk;
  logic        rst_n;
  logic        imem_ren;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        ebreak;
  logic        trap;

  // Word-addressed instruction ROM and data RAM
  logic [31:0] rom [ROM_WORDS];
  logic [31:0] ram [RAM_WORDS];

  // Program table columns
  rv_op_e      row_op   [MAX_ROWS];
  logic [4:0]  row_rd   [MAX_ROWS];
  logic [4:0]  row_rs1  [MAX_ROWS];
  logic [4:0]  row_rs2  [MAX_ROWS];
  logic [31:0] row_imm  [MAX_ROWS];
  logic        row_st   [MAX_ROWS];
  logic [31:0] row_addr [MAX_ROWS];
  logic [31:0] row_data [MAX_ROWS];
  int          row_cnt;

  // Expected stores in program order
  logic [31:0] exp_addr [MAX_ROWS];
  logic [31:0] exp_data [MAX_ROWS];
  int          exp_cnt   = 0;
  int          store_ptr = 0;

  // Data reads seen and expected
  int          load_cnt  = 0;
  int          exp_loads = 0;

  int          checks = 0;
  int          errors = 0;

  rv_core UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ----------------------------------------
  // Memory models
  // ----------------------------------------
  // Same-cycle read data
  assign imem_rdata = rom[imem_raddr[7:2]];
  // Load data only while dmem_ren is high
  assign dmem_rdata = dmem_ren ? ram[dmem_raddr[9:2]] : 32'hbad0_0bad;

  // RAM refilled with its own byte address during reset
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        ram[i] <= 32'hda7a_0000 | (i << 2);
      end
    end else if (dmem_we) begin
      ram[dmem_waddr[9:2]] <= dmem_wdata;
    end
  end

  // ----------------------------------------
  // Store checker
  // ----------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      store_ptr <= 0;
      load_cnt  <= 0;
    end else begin
      if (dmem_ren) begin
        load_cnt <= load_cnt + 1;
      end
      if (dmem_we) begin
        if (store_ptr < exp_cnt) begin
          check_value("dmem_waddr", dmem_waddr, exp_addr[store_ptr]);
          check_value("dmem_wdata", dmem_wdata, exp_data[store_ptr]);
          check_value("dmem_wstrb", {28'd0, dmem_wstrb}, 32'h0000_000f);
          store_ptr <= store_ptr + 1;
        end else begin
          errors++;
          $display("Unexpected store of %h to address %h at %0t", dmem_wdata, dmem_waddr,
                   $time);
        end
      end
    end
  end

  // Mismatch report with time and both values
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // RV32I encoding of one table row
  function automatic logic [31:0] encode_instr(input rv_op_e op, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [31:0] imm);
    case (op)
      OP_LUI:  return {imm[31:12], rd, OPC_LUI};
      OP_ADDI: return {imm[11:0], rs1, 3'b000, rd, OPC_OP_IMM};
      OP_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP_REG};
      OP_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP_REG};
      OP_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP_REG};
      OP_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP_REG};
      OP_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP_REG};
      OP_LW:   return {imm[11:0], rs1, 3'b010, rd, OPC_LOAD};
      OP_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
      OP_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
      OP_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OPC_BRANCH};
      OP_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
      OP_EBREAK: return 32'h0010_0073;
      // Raw word taken from the imm column
      OP_ILLEGAL: return imm;
      default: return 32'h0000_0013;
    endcase
  endfunction

  task automatic add_row(input rv_op_e op, input int rd, input int rs1, input int rs2,
                         input logic [31:0] imm, input bit st, input logic [31:0] addr,
                         input logic [31:0] data);
    row_op[row_cnt]   = op;
    row_rd[row_cnt]   = 5'(rd);
    row_rs1[row_cnt]  = 5'(rs1);
    row_rs2[row_cnt]  = 5'(rs2);
    row_imm[row_cnt]  = imm;
    row_st[row_cnt]   = st;
    row_addr[row_cnt] = addr;
    row_data[row_cnt] = data;
    row_cnt++;
  endtask

  // ----------------------------------------
  // Program tables
  // ----------------------------------------
  // Column order is op, rd, rs1, rs2, imm, store flag, store address, store data
  task automatic build_main_table();
    add_row(OP_ADDI, 10, 0, 0, BASE, 0, 0, 0);
    add_row(OP_LUI, 1, 0, 0, V1, 0, 0, 0);
    add_row(OP_ADDI, 2, 0, 0, V2, 0, 0, 0);
    add_row(OP_ADDI, 3, 0, 0, V3, 0, 0, 0);
    add_row(OP_ADD, 4, 1, 2, 0, 0, 0, 0);
    add_row(OP_SUB, 5, 2, 3, 0, 0, 0, 0);
    add_row(OP_AND, 6, 1, 3, 0, 0, 0, 0);
    add_row(OP_OR, 7, 2, 3, 0, 0, 0, 0);
    add_row(OP_XOR, 8, 1, 3, 0, 0, 0, 0);
    add_row(OP_SW, 0, 10, 4, 0, 1, BASE, V1 + V2);
    add_row(OP_SW, 0, 10, 5, 4, 1, BASE + 4, V2 - V3);
    add_row(OP_SW, 0, 10, 6, 8, 1, BASE + 8, V1 & V3);
    add_row(OP_SW, 0, 10, 7, 12, 1, BASE + 12, V2 | V3);
    add_row(OP_SW, 0, 10, 8, 16, 1, BASE + 16, V1 ^ V3);
    add_row(OP_SW, 0, 10, 1, 20, 1, BASE + 20, V1);
    add_row(OP_SW, 0, 10, 3, 24, 1, BASE + 24, V3);
    // Back-to-back dependent chain
    add_row(OP_ADDI, 11, 1, 0, 32'h123, 0, 0, 0);
    add_row(OP_ADD, 12, 11, 2, 0, 0, 0, 0);
    add_row(OP_SUB, 13, 12, 11, 0, 0, 0, 0);
    add_row(OP_XOR, 14, 13, 12, 0, 0, 0, 0);
    add_row(OP_SW, 0, 10, 14, 28, 1, BASE + 28, V14);
    // Store a word, load it back and store the copy elsewhere
    add_row(OP_SW, 0, 10, 4, 32, 1, BASE + 32, V1 + V2);
    add_row(OP_LW, 15, 10, 0, 32, 0, 0, 0);
    add_row(OP_SW, 0, 10, 15, 36, 1, BASE + 36, V1 + V2);
    // Taken BEQ flushes the two stores behind it
    add_row(OP_BEQ, 0, 2, 2, 12, 0, 0, 0);
    add_row(OP_SW, 0, 10, 1, 40, 0, 0, 0);
    add_row(OP_SW, 0, 10, 2, 44, 0, 0, 0);
    // Taken BNE
    add_row(OP_BNE, 0, 2, 3, 12, 0, 0, 0);
    add_row(OP_SW, 0, 10, 3, 48, 0, 0, 0);
    add_row(OP_SW, 0, 10, 3, 52, 0, 0, 0);
    // Not-taken branches fall through
    add_row(OP_BEQ, 0, 2, 3, 8, 0, 0, 0);
    add_row(OP_SW, 0, 10, 2, 56, 1, BASE + 56, V2);
    add_row(OP_BNE, 0, 2, 2, 8, 0, 0, 0);
    add_row(OP_SW, 0, 10, 3, 60, 1, BASE + 60, V3);
    // JAL link saved by the store at its target
    add_row(OP_JAL, 16, 0, 0, 12, 0, 0, 0);
    add_row(OP_SW, 0, 10, 1, 64, 0, 0, 0);
    add_row(OP_SW, 0, 10, 1, 68, 0, 0, 0);
    add_row(OP_SW, 0, 10, 16, 72, 1, BASE + 72, JAL_PC + 4);
    add_row(OP_EBREAK, 0, 0, 0, 0, 0, 0, 0);
    // Never issued
    add_row(OP_SW, 0, 10, 2, 76, 0, 0, 0);
  endtask

  // Short program ending on an ECALL word that this core treats as illegal
  task automatic build_trap_table();
    add_row(OP_ADDI, 20, 0, 0, 32'h55, 0, 0, 0);
    add_row(OP_SW, 0, 0, 20, 32'h80, 1, 32'h80, 32'h55);
    add_row(OP_ILLEGAL, 0, 0, 0, 32'h0000_0073, 0, 0, 0);
    add_row(OP_SW, 0, 0, 20, 32'h84, 0, 0, 0);
  endtask

  // Encode rows into the ROM and collect the expected stores
  task automatic load_program();
    exp_cnt   = 0;
    exp_loads = 0;
    for (int i = 0; i < ROM_WORDS; i++) begin
      if (i < row_cnt) begin
        rom[i] = encode_instr(row_op[i], row_rd[i], row_rs1[i], row_rs2[i], row_imm[i]);
        if (row_st[i]) begin
          exp_addr[exp_cnt] = row_addr[i];
          exp_data[exp_cnt] = row_data[i];
          exp_cnt++;
        end
        // Every LW row lies on the executed path and reads for one cycle
        if (row_op[i] == OP_LW) begin
          exp_loads++;
        end
      end else begin
        // Zero opcode field decodes as illegal
        rom[i] = i << 7;
      end
    end
  endtask

  task automatic close_run();
    $display("Closing report: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // ----------------------------------------
  // One program from reset to halt
  // ----------------------------------------
  task automatic run_program(input bit trap_run);
    int cycles;
    int limit;
    @(posedge clk);
    rst_n <= 1'b0;
    row_cnt = 0;
    if (trap_run) begin
      build_trap_table();
    end else begin
      build_main_table();
    end
    load_program();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // Ten cycles per row plus slack
    limit  = 10 * row_cnt + 50;
    cycles = 0;
    while (!ebreak && !trap && (cycles < limit)) begin
      @(posedge clk);
      cycles++;
      // Fetch stays enabled once the core is out of reset
      if (cycles > 1) begin
        check_value("imem_ren", {31'd0, imem_ren}, 32'd1);
      end
    end
    if (cycles >= limit) begin
      errors++;
      $display("Timeout: the core did not halt within %0d cycles", limit);
      close_run();
    end else begin
      // Flags must stay put after halt
      repeat (4) @(posedge clk);
      check_value("ebreak", {31'd0, ebreak}, trap_run ? 32'd0 : 32'd1);
      check_value("trap", {31'd0, trap}, trap_run ? 32'd1 : 32'd0);
      check_value("dmem_ren cycles", 32'(load_cnt), 32'(exp_loads));
      if (store_ptr != exp_cnt) begin
        errors++;
        $display("Missing store: only %0d of %0d expected stores appeared", store_ptr, exp_cnt);
      end
    end
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    run_program(1'b0);
    run_program(1'b1);
    close_run();
  end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst_n,
  output logic                imem_ren,
  output logic [`RV_XLEN-1:0] imem_raddr,
  input  logic [31:0]         imem_rdata,
  output logic                dmem_ren,
  output logic [31:0]         dmem_raddr,
  input  logic [31:0]         dmem_rdata,
  output logic                dmem_we,
  output logic [31:0]         dmem_waddr,
  output logic [31:0]         dmem_wdata,
  output logic [3:0]          dmem_wstrb,
  output logic                ebreak,
  output logic                trap
);

  // Fetch to decode
  logic                  fd_valid;
  logic [`RV_XLEN-1:0]   fd_pc;
  logic [31:0]           fd_instr;

  // Pipeline control
  logic                  hold;
  logic                  redirect;
  logic [`RV_XLEN-1:0]   redirect_pc;

  // Register write-back into decode
  logic                  wb_we;
  logic [`RV_REG_AW-1:0] wb_rd;
  logic [`RV_XLEN-1:0]   wb_data;

  // ----------------------------------------
  // Stage boundaries
  // ----------------------------------------
  rv_stage_if de_ex ();
  rv_stage_if ex_mem ();
  rv_stage_if mem_wb ();

  rv_fetch u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .hold        (hold),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_ren    (imem_ren),
    .imem_raddr  (imem_raddr),
    .imem_rdata  (imem_rdata),
    .fd_valid    (fd_valid),
    .fd_pc       (fd_pc),
    .fd_instr    (fd_instr)
  );

  rv_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .fd_valid    (fd_valid),
    .fd_pc       (fd_pc),
    .fd_instr    (fd_instr),
    .redirect    (redirect),
    .wb_we       (wb_we),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .hold        (hold),
    .de_ex       (de_ex),
    .ex_mem_peek (ex_mem),
    .mem_wb_peek (mem_wb)
  );

  rv_execute u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .de_ex       (de_ex),
    .ex_mem      (ex_mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  rv_memory u_memory (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_mem      (ex_mem),
    .mem_wb      (mem_wb),
    .dmem_ren    (dmem_ren),
    .dmem_raddr  (dmem_raddr),
    .dmem_rdata  (dmem_rdata),
    .dmem_we     (dmem_we),
    .dmem_waddr  (dmem_waddr),
    .dmem_wdata  (dmem_wdata),
    .dmem_wstrb  (dmem_wstrb)
  );

  rv_writeback u_writeback (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_wb      (mem_wb),
    .wb_we       (wb_we),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .ebreak      (ebreak),
    .trap        (trap)
  );

endmodule

//--- logic/rv_writeback.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_writeback import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  rv_stage_if.sink              mem_wb,
  output logic                  wb_we,
  output logic [`RV_REG_AW-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]   wb_data,
  output logic                  ebreak,
  output logic                  trap
);

  // ----------------------------------------
  // Register write port
  // ----------------------------------------
  // x0 is never written
  assign wb_we   = mem_wb.valid && rv_writes_rd(mem_wb.op) && (mem_wb.rd != '0);
  assign wb_rd   = mem_wb.rd;
  assign wb_data = mem_wb.result;

  // ----------------------------------------
  // Halt flags
  // ----------------------------------------
  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      if (mem_wb.valid && (mem_wb.op == OP_EBREAK)) begin
        ebreak <= 1'b1;
      end
      if (mem_wb.valid && (mem_wb.op == OP_ILLEGAL)) begin
        trap <= 1'b1;
      end
    end
  end

endmodule

//--- logic/rv_memory.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_memory import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  rv_stage_if.sink    ex_mem,
  rv_stage_if.source  mem_wb,
  output logic        dmem_ren,
  output logic [31:0] dmem_raddr,
  input  logic [31:0] dmem_rdata,
  output logic        dmem_we,
  output logic [31:0] dmem_waddr,
  output logic [31:0] dmem_wdata,
  output logic [3:0]  dmem_wstrb
);

  // ----------------------------------------
  // Data memory port
  // ----------------------------------------
  assign dmem_ren   = ex_mem.valid && (ex_mem.op == OP_LW);
  assign dmem_raddr = ex_mem.result;

  // Full word stores only
  assign dmem_we    = ex_mem.valid && (ex_mem.op == OP_SW);
  assign dmem_waddr = ex_mem.result;
  assign dmem_wdata = ex_mem.b;
  assign dmem_wstrb = dmem_we ? 4'b1111 : 4'b0000;

  // ----------------------------------------
  // Memory/writeback register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb.valid <= 1'b0;
    end else begin
      mem_wb.valid <= ex_mem.valid;
    end
  end

  // Load data replaces the address
  always_ff @(posedge clk) begin
    mem_wb.op     <= ex_mem.op;
    mem_wb.rd     <= ex_mem.rd;
    mem_wb.result <= (ex_mem.op == OP_LW) ? dmem_rdata : ex_mem.result;
  end

  assign mem_wb.pc  = '0;
  assign mem_wb.a   = '0;
  assign mem_wb.b   = '0;
  assign mem_wb.imm = '0;

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_execute import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  rv_stage_if.sink            de_ex,
  rv_stage_if.source          ex_mem,
  output logic                redirect,
  output logic [`RV_XLEN-1:0] redirect_pc
);

  logic [`RV_XLEN-1:0] alu;
  logic                taken;

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  always_comb begin
    case (de_ex.op)
      OP_LUI:  alu = de_ex.imm;
      OP_ADDI: alu = de_ex.a + de_ex.imm;
      OP_ADD:  alu = de_ex.a + de_ex.b;
      OP_SUB:  alu = de_ex.a - de_ex.b;
      OP_AND:  alu = de_ex.a & de_ex.b;
      OP_OR:   alu = de_ex.a | de_ex.b;
      OP_XOR:  alu = de_ex.a ^ de_ex.b;
      // Effective address for memory ops
      OP_LW,
      OP_SW:   alu = de_ex.a + de_ex.imm;
      // Link value
      OP_JAL:  alu = de_ex.pc + `RV_XLEN'd4;
      default: alu = '0;
    endcase
  end

  // ----------------------------------------
  // Branch compare and redirect
  // ----------------------------------------
  always_comb begin
    case (de_ex.op)
      OP_BEQ:  taken = (de_ex.a == de_ex.b);
      OP_BNE:  taken = (de_ex.a != de_ex.b);
      OP_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // Same-cycle pulse, fetch and decode drop the two younger slots
  assign redirect    = de_ex.valid && taken;
  assign redirect_pc = de_ex.pc + de_ex.imm;

  // ----------------------------------------
  // Execute/memory register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else begin
      // Decode already bubbles anything younger than a redirect
      ex_mem.valid <= de_ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem.op     <= de_ex.op;
    ex_mem.rd     <= de_ex.rd;
    ex_mem.result <= alu;
    // Store data rides in b
    ex_mem.b      <= de_ex.b;
  end

  // Fields not needed past execute
  assign ex_mem.pc  = '0;
  assign ex_mem.a   = '0;
  assign ex_mem.imm = '0;

endmodule

//--- logic/rv_decode.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_decode import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fd_valid,
  input  logic [`RV_XLEN-1:0]   fd_pc,
  input  logic [31:0]           fd_instr,
  input  logic                  redirect,
  input  logic                  wb_we,
  input  logic [`RV_REG_AW-1:0] wb_rd,
  input  logic [`RV_XLEN-1:0]   wb_data,
  output logic                  hold,
  rv_stage_if.source            de_ex,
  rv_stage_if.peek              ex_mem_peek,
  rv_stage_if.peek              mem_wb_peek
);

  rv_opcode_e            opcode;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  rv_op_e                op;
  logic [`RV_XLEN-1:0]   imm;
  logic                  use_rs1;
  logic                  use_rs2;
  logic [`RV_XLEN-1:0]   regs [`RV_NREGS];
  logic [`RV_XLEN-1:0]   rs1_val;
  logic [`RV_XLEN-1:0]   rs2_val;
  logic                  hazard;
  logic                  issue;
  // Set once a halting instruction has gone out
  logic                  stopped;

  assign opcode = rv_opcode_e'(fd_instr[6:0]);
  assign rs1    = fd_instr[19:15];
  assign rs2    = fd_instr[24:20];

  // ----------------------------------------
  // Instruction decode
  // ----------------------------------------
  always_comb begin
    op      = OP_ILLEGAL;
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OPC_LUI: begin
        op  = OP_LUI;
        imm = {fd_instr[31:12], 12'b0};
      end
      OPC_OP_IMM: begin
        if (fd_instr[14:12] == 3'b000) begin
          op      = OP_ADDI;
          use_rs1 = 1'b1;
        end
        imm = {{20{fd_instr[31]}}, fd_instr[31:20]};
      end
      OPC_OP_REG: begin
        // funct7 and funct3 together pick the ALU op
        case ({fd_instr[31:25], fd_instr[14:12]})
          10'b0000000_000: op = OP_ADD;
          10'b0100000_000: op = OP_SUB;
          10'b0000000_111: op = OP_AND;
          10'b0000000_110: op = OP_OR;
          10'b0000000_100: op = OP_XOR;
          default:         op = OP_ILLEGAL;
        endcase
        use_rs1 = (op != OP_ILLEGAL);
        use_rs2 = (op != OP_ILLEGAL);
      end
      OPC_LOAD: begin
        // Word loads only
        if (fd_instr[14:12] == 3'b010) begin
          op      = OP_LW;
          use_rs1 = 1'b1;
        end
        imm = {{20{fd_instr[31]}}, fd_instr[31:20]};
      end
      OPC_STORE: begin
        if (fd_instr[14:12] == 3'b010) begin
          op      = OP_SW;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
        imm = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
      end
      OPC_BRANCH: begin
        if (fd_instr[14:12] == 3'b000) begin
          op = OP_BEQ;
        end else if (fd_instr[14:12] == 3'b001) begin
          op = OP_BNE;
        end
        use_rs1 = (op != OP_ILLEGAL);
        use_rs2 = (op != OP_ILLEGAL);
        imm = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7], fd_instr[30:25],
               fd_instr[11:8], 1'b0};
      end
      OPC_JAL: begin
        op  = OP_JAL;
        imm = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12], fd_instr[20],
               fd_instr[30:21], 1'b0};
      end
      OPC_SYSTEM: begin
        // Exact EBREAK encoding, everything else in SYSTEM traps
        if (fd_instr == 32'h0010_0073) begin
          op = OP_EBREAK;
        end
      end
      default: op = OP_ILLEGAL;
    endcase
  end

  // ----------------------------------------
  // Register file
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wb_we) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // x0 reads zero, value leaving writeback is passed straight through
  always_comb begin
    if (rs1 == '0) begin
      rs1_val = '0;
    end else if (mem_wb_peek.valid && wb_we && (wb_rd == rs1)) begin
      rs1_val = wb_data;
    end else begin
      rs1_val = regs[rs1];
    end
    if (rs2 == '0) begin
      rs2_val = '0;
    end else if (mem_wb_peek.valid && wb_we && (wb_rd == rs2)) begin
      rs2_val = wb_data;
    end else begin
      rs2_val = regs[rs2];
    end
  end

  // ----------------------------------------
  // Hazard hold and issue
  // ----------------------------------------
  // Producers still in execute or memory have not written back yet
  always_comb begin
    hazard = 1'b0;
    if (de_ex.valid && rv_writes_rd(de_ex.op) && (de_ex.rd != '0)) begin
      hazard = (use_rs1 && (de_ex.rd == rs1)) || (use_rs2 && (de_ex.rd == rs2));
    end
    if (ex_mem_peek.valid && rv_writes_rd(ex_mem_peek.op) && (ex_mem_peek.rd != '0)) begin
      hazard = hazard || (use_rs1 && (ex_mem_peek.rd == rs1)) ||
               (use_rs2 && (ex_mem_peek.rd == rs2));
    end
  end

  assign hold  = fd_valid && hazard;
  assign issue = fd_valid && !hazard && !stopped && !redirect;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      de_ex.valid <= 1'b0;
      stopped     <= 1'b0;
    end else begin
      de_ex.valid <= issue;
      if (issue && ((op == OP_EBREAK) || (op == OP_ILLEGAL))) begin
        stopped <= 1'b1;
      end
    end
  end

  // Slot payload, qualified by valid downstream
  always_ff @(posedge clk) begin
    de_ex.pc  <= fd_pc;
    de_ex.op  <= op;
    de_ex.rd  <= fd_instr[11:7];
    de_ex.a   <= rs1_val;
    de_ex.b   <= rs2_val;
    de_ex.imm <= imm;
  end

  // Result is produced from execute on
  assign de_ex.result = '0;

endmodule

//--- logic/rv_fetch.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                hold,
  input  logic                redirect,
  input  logic [`RV_XLEN-1:0] redirect_pc,
  output logic                imem_ren,
  output logic [`RV_XLEN-1:0] imem_raddr,
  input  logic [31:0]         imem_rdata,
  output logic                fd_valid,
  output logic [`RV_XLEN-1:0] fd_pc,
  output logic [31:0]         fd_instr
);

  // Fetch enable, set one cycle after reset release
  logic                run;
  logic [`RV_XLEN-1:0] pc;

  assign imem_ren   = run;
  // SRAM answers in the same cycle
  assign imem_raddr = pc;

  // ----------------------------------------
  // Program counter and slot valid
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run      <= 1'b0;
      pc       <= `RV_RESET_PC;
      fd_valid <= 1'b0;
    end else begin
      run <= 1'b1;
      // Redirect wins over hold and drops the fetched word
      if (redirect) begin
        pc       <= redirect_pc;
        fd_valid <= 1'b0;
      end else if (run && !hold) begin
        pc       <= pc + `RV_XLEN'd4;
        fd_valid <= 1'b1;
      end
    end
  end

  // Fetched word and its address
  always_ff @(posedge clk) begin
    if (run && !hold && !redirect) begin
      fd_pc    <= pc;
      fd_instr <= imem_rdata;
    end
  end

endmodule

//--- logic/rv_stage_if.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

// One pipeline boundary slot
interface rv_stage_if import rv_pkg::*; ();

  // Slot holds a real instruction, low for a bubble
  logic                  valid;
  logic [`RV_XLEN-1:0]   pc;
  rv_op_e                op;
  logic [`RV_REG_AW-1:0] rd;
  // Operand values, b doubles as store data
  logic [`RV_XLEN-1:0]   a;
  logic [`RV_XLEN-1:0]   b;
  logic [`RV_XLEN-1:0]   imm;
  // ALU value, link, address or load data
  logic [`RV_XLEN-1:0]   result;

  // Producing stage
  modport source(output valid, pc, op, rd, a, b, imm, result);

  // Consuming stage
  modport sink(input valid, pc, op, rd, a, b, imm, result);

  // Hazard lookup from decode
  modport peek(input valid, op, rd);

endinterface

//--- logic/rv_pkg.sv
package rv_pkg;

  // ----------------------------------------
  // Decoded operations
  // ----------------------------------------
  typedef enum logic [3:0] {
    OP_NOP,
    OP_LUI,
    OP_ADDI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_LW,
    OP_SW,
    OP_BEQ,
    OP_BNE,
    OP_JAL,
    OP_EBREAK,
    OP_ILLEGAL
  } rv_op_e;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP_REG = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } rv_opcode_e;

  // True for operations that produce a register result
  function automatic logic rv_writes_rd(rv_op_e op);
    case (op)
      OP_LUI, OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LW, OP_JAL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

//--- logic/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// ----------------------------------------
// Core configuration
// ----------------------------------------

// Data and address width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// Register index width
`define RV_REG_AW 5

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
